/* lsu.f */
hdl/lsuPkg.sv
hdl/memReqIf.sv
hdl/cacheArrays.sv
hdl/lineDatapath.sv
hdl/memEngine.sv
hdl/lsuControl.sv
hdl/loadStoreUnit.sv
bench/lsuMemModel.sv
bench/lsuTb.sv

/* Makefile */
# Verilator build and run for the lsu testbench

VERILATOR ?= verilator
TOP ?= lsuTb
FILELIST ?= lsu.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The log search decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/lsuTb.sv */
// ########################################
// Stops at the first error, every wait has a timeout
// Shadow copy of memory predicts all results
// ########################################
`timescale 1ns/1ps

module lsuTb import lsuPkg::*; ();

    typedef struct packed {
        lsuCmdT cmd;
        accessSizeT size;
        logic isSigned;
        amoFuncT amoFunc;
        logic backdoor;
        addrT addr;
        wordT data;
        logic expErr;
    } stepT;

    logic clk = 1'b0;
    logic rst;
    logic psel;
    logic penable;
    addrT paddr;
    lsuCmdT cmd;
    accessSizeT size;
    logic isSigned;
    amoFuncT amoFunc;
    wordT pwdata;
    wordT prdata;
    logic pready;
    logic pslverr;
    logic memPsel;
    logic memPenable;
    logic memPwrite;
    addrT memPaddr;
    wordT memPwdata;
    logic [wordBytes-1:0] memPstrb;
    wordT memPrdata;
    logic memPready;
    logic pokeEn;
    addrT pokeAddr;
    wordT pokeData;

    wordT shadow [1 << (addrWidth - 2)];

    stepT steps [36] = '{
        // Cold misses, then hits on the same lines
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0100, 32'h00000000, 1'b0},
        '{CmdLoad, SizeByte, 1'b0, AmoSwap, 1'b0, 16'h0103, 32'h00000000, 1'b0},
        '{CmdLoad, SizeByte, 1'b1, AmoSwap, 1'b0, 16'h0101, 32'h00000000, 1'b0},
        '{CmdLoad, SizeHalf, 1'b1, AmoSwap, 1'b0, 16'h0106, 32'h00000000, 1'b0},
        '{CmdLoad, SizeHalf, 1'b0, AmoSwap, 1'b0, 16'h010a, 32'h00000000, 1'b0},
        '{CmdLoad, SizeByte, 1'b1, AmoSwap, 1'b0, 16'h0235, 32'h00000000, 1'b0},
        '{CmdLoad, SizeHalf, 1'b0, AmoSwap, 1'b0, 16'h0342, 32'h00000000, 1'b0},
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0344, 32'h00000000, 1'b0},
        // Stores on hit and on miss, then reload the merged words
        '{CmdStore, SizeByte, 1'b0, AmoSwap, 1'b0, 16'h0105, 32'h000000a5, 1'b0},
        '{CmdStore, SizeHalf, 1'b0, AmoSwap, 1'b0, 16'h010e, 32'h00008123, 1'b0},
        '{CmdStore, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0108, 32'hdeadbeef, 1'b0},
        '{CmdStore, SizeByte, 1'b0, AmoSwap, 1'b0, 16'h0451, 32'h0000007f, 1'b0},
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0104, 32'h00000000, 1'b0},
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h010c, 32'h00000000, 1'b0},
        '{CmdLoad, SizeByte, 1'b1, AmoSwap, 1'b0, 16'h0105, 32'h00000000, 1'b0},
        '{CmdLoad, SizeByte, 1'b0, AmoSwap, 1'b0, 16'h0105, 32'h00000000, 1'b0},
        '{CmdLoad, SizeHalf, 1'b0, AmoSwap, 1'b0, 16'h010e, 32'h00000000, 1'b0},
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0450, 32'h00000000, 1'b0},
        // Atomics on one word, top bits set for min/max
        '{CmdStore, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0500, 32'h80000010, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0500, 32'h00000005, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoAdd, 1'b0, 16'h0500, 32'h7ffffff0, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoXor, 1'b0, 16'h0500, 32'h0f0f0f0f, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoAnd, 1'b0, 16'h0500, 32'hfff0fff0, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoOr, 1'b0, 16'h0500, 32'h80000001, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoMin, 1'b0, 16'h0500, 32'h00000007, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoMax, 1'b0, 16'h0500, 32'h00000003, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoMinu, 1'b0, 16'h0500, 32'hf0000000, 1'b0},
        '{CmdAmo, SizeWord, 1'b0, AmoMaxu, 1'b0, 16'h0500, 32'hc0000000, 1'b0},
        // Misaligned accesses must leave everything alone
        '{CmdLoad, SizeHalf, 1'b0, AmoSwap, 1'b0, 16'h0101, 32'h00000000, 1'b1},
        '{CmdStore, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0502, 32'h11111111, 1'b1},
        '{CmdAmo, SizeWord, 1'b0, AmoAdd, 1'b0, 16'h0506, 32'h22222222, 1'b1},
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0500, 32'h00000000, 1'b0},
        // Invalidate, change memory behind the cache, reload
        '{CmdInvalidate, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0000, 32'h00000000, 1'b0},
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b1, 16'h0500, 32'h97532468, 1'b0},
        '{CmdLoad, SizeWord, 1'b0, AmoSwap, 1'b0, 16'h0500, 32'h00000000, 1'b0},
        '{CmdLoad, SizeHalf, 1'b1, AmoSwap, 1'b0, 16'h0502, 32'h00000000, 1'b0}
    };

    loadStoreUnit dut_i (.*);

    lsuMemModel memModel_i (.*);

    always #20 clk = ~clk;

    task automatic failTest(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT expected);
        if (got !== expected) begin
            failTest($sformatf("mismatch %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic checkErr(input logic got, input logic expected);
        if (got !== expected) begin
            failTest($sformatf("mismatch pslverr got %h expected %h", got, expected));
        end
    endtask

    task automatic checkMem(input addrT addr);
        wordT got;
        wordT expected;
        got = memModel_i.words[addr[addrWidth-1:2]];
        expected = shadow[addr[addrWidth-1:2]];
        if (got !== expected) begin
            failTest($sformatf("mismatch memory[%h] got %h expected %h",
                               {addr[addrWidth-1:2], 2'b00}, got, expected));
        end
    endtask

    function automatic wordT expectLoad(input addrT addr, input accessSizeT sz, input logic sgn);
        wordT w;
        w = shadow[addr[addrWidth-1:2]] >> (8 * addr[1:0]);
        case (sz)
            SizeByte: return sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
            SizeHalf: return sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
            default:  return w;
        endcase
    endfunction

    function automatic wordT amoResult(input amoFuncT func, input wordT src, input wordT old);
        case (func)
            AmoSwap: return src;
            AmoAdd:  return old + src;
            AmoXor:  return old ^ src;
            AmoAnd:  return old & src;
            AmoOr:   return old | src;
            AmoMin:  return ($signed(old) < $signed(src)) ? old : src;
            AmoMax:  return ($signed(old) > $signed(src)) ? old : src;
            AmoMinu: return (old < src) ? old : src;
            default: return (old > src) ? old : src;
        endcase
    endfunction

    task automatic updateShadow(input addrT addr, input accessSizeT sz, input wordT value);
        wordT w;
        int count;
        w = shadow[addr[addrWidth-1:2]];
        count = (sz == SizeByte) ? 1 : (sz == SizeHalf) ? 2 : 4;
        for (int b = 0; b < count; b++) begin
            w[8 * (addr[1:0] + b) +: 8] = value[8*b +: 8];
        end
        shadow[addr[addrWidth-1:2]] = w;
    endtask

    task automatic pokeWord(input addrT addr, input wordT value);
        @(posedge clk);
        #2;
        pokeEn = 1'b1;
        pokeAddr = addr;
        pokeData = value;
        @(posedge clk);
        #2;
        pokeEn = 1'b0;
    endtask

    // Setup phase, access phase, then hold until pready
    task automatic runAccess(input stepT s, output wordT data, output logic err);
        int waited;
        @(posedge clk);
        #2;
        psel = 1'b1;
        penable = 1'b0;
        paddr = s.addr;
        cmd = s.cmd;
        size = s.size;
        isSigned = s.isSigned;
        amoFunc = s.amoFunc;
        pwdata = s.data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waited = 0;
        while (!pready) begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > 2000) begin
                failTest($sformatf("timeout waiting for pready at address %h", s.addr));
            end
        end
        data = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        stepT s;
        wordT expData;
        wordT gotData;
        logic gotErr;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        paddr = '0;
        cmd = CmdLoad;
        size = SizeWord;
        isSigned = 1'b0;
        amoFunc = AmoSwap;
        pwdata = '0;
        pokeEn = 1'b0;
        pokeAddr = '0;
        pokeData = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < $size(shadow); i++) begin
            shadow[i] = memModel_i.words[i];
        end
        for (int i = 0; i < $size(steps); i++) begin
            s = steps[i];
            if (s.backdoor) begin
                pokeWord(s.addr, s.data);
                shadow[s.addr[addrWidth-1:2]] = s.data;
            end else begin
                expData = '0;
                if (s.cmd == CmdLoad) begin
                    expData = expectLoad(s.addr, s.size, s.isSigned);
                end else if (s.cmd == CmdAmo) begin
                    expData = shadow[s.addr[addrWidth-1:2]];
                end
                runAccess(s, gotData, gotErr);
                checkErr(gotErr, s.expErr);
                if (!s.expErr) begin
                    checkWord("prdata", gotData, expData);
                    if (s.cmd == CmdStore) begin
                        updateShadow(s.addr, s.size, s.data);
                    end else if (s.cmd == CmdAmo) begin
                        updateShadow(s.addr, SizeWord, amoResult(s.amoFunc, s.data, expData));
                    end
                end
                if (s.cmd == CmdStore || s.cmd == CmdAmo) begin
                    checkMem(s.addr);
                end
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* bench/lsuMemModel.sv */
// ########################################
// APB memory, 64 KB, 0 to 3 wait states
// Contents refilled from the LFSR on every reset cycle
// ########################################
`timescale 1ns/1ps

module lsuMemModel import lsuPkg::*; (
    input logic clk,
    input logic rst,
    input logic memPsel,
    input logic memPenable,
    input logic memPwrite,
    input addrT memPaddr,
    input wordT memPwdata,
    input logic [wordBytes-1:0] memPstrb,
    output wordT memPrdata,
    output logic memPready,
    input logic pokeEn,
    input addrT pokeAddr,
    input wordT pokeData
);

    wordT words [1 << (addrWidth - 2)];
    logic [31:0] lfsr;
    logic [1:0] waitLeft;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] drawBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return value;
    endfunction

    assign memPready = memPsel && memPenable && (waitLeft == 2'd0);
    assign memPrdata = words[memPaddr[addrWidth-1:2]];

    always @(posedge clk) begin
        if (rst) begin
            lfsr = 32'h826deebb;
            for (int i = 0; i < $size(words); i++) begin
                words[i] = drawBits(32);
            end
            waitLeft <= 2'd0;
        end else begin
            if (memPsel && !memPenable) begin
                waitLeft <= 2'(drawBits(2));
            end else if (memPsel && memPenable && waitLeft != 2'd0) begin
                waitLeft <= waitLeft - 2'd1;
            end
            if (memPready && memPwrite) begin
                for (int b = 0; b < wordBytes; b++) begin
                    if (memPstrb[b]) begin
                        words[memPaddr[addrWidth-1:2]][8*b +: 8] = memPwdata[8*b +: 8];
                    end
                end
            end
            // Backdoor write, bypasses the bus
            if (pokeEn) begin
                words[pokeAddr[addrWidth-1:2]] = pokeData;
            end
        end
    end

endmodule

/* hdl/loadStoreUnit.sv */
// ########################################
// CPU side APB completer, memory side APB requester
// Sidebands held stable while psel is high
// ########################################
`timescale 1ns/1ps

module loadStoreUnit import lsuPkg::*; (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input addrT paddr,
    input lsuCmdT cmd,
    input accessSizeT size,
    input logic isSigned,
    input amoFuncT amoFunc,
    input wordT pwdata,
    output wordT prdata,
    output logic pready,
    output logic pslverr,
    output logic memPsel,
    output logic memPenable,
    output logic memPwrite,
    output addrT memPaddr,
    output wordT memPwdata,
    output logic [wordBytes-1:0] memPstrb,
    input wordT memPrdata,
    input logic memPready
);

    memReqIf memBus ();

    indexT tagIndex;
    logic readValid;
    tagT readTag;
    lineT readLine;
    wordT loadWord;
    lineT mergeLine;
    byteMaskT mergeMask;
    lineT writeLine;
    byteMaskT writeMask;
    logic dataWrite;
    logic tagWrite;
    logic writeValid;
    tagT writeTag;

    lsuControl control_i (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .paddr(paddr),
        .cmd(cmd), .size(size), .pready(pready), .pslverr(pslverr), .prdata(prdata),
        .mem(memBus), .tagIndex(tagIndex), .readValid(readValid), .readTag(readTag),
        .loadWord(loadWord), .mergeLine(mergeLine), .mergeMask(mergeMask),
        .storeLine(writeLine), .storeMask(writeMask), .dataWrite(dataWrite),
        .tagWrite(tagWrite), .writeValid(writeValid), .writeTag(writeTag)
    );

    cacheArrays arrays_i (
        .clk(clk), .rst(rst), .index(tagIndex), .tagWrite(tagWrite),
        .writeValid(writeValid), .writeTag(writeTag), .dataWrite(dataWrite),
        .writeLine(writeLine), .writeMask(writeMask), .readValid(readValid),
        .readTag(readTag), .readLine(readLine)
    );

    lineDatapath datapath_i (
        .line(readLine), .offset(paddr[offsetWidth-1:0]), .size(size),
        .isSigned(isSigned), .isAmo(cmd == CmdAmo), .amoFunc(amoFunc),
        .storeData(pwdata), .loadWord(loadWord), .storeLine(mergeLine),
        .storeMask(mergeMask)
    );

    memEngine engine_i (
        .clk(clk), .rst(rst), .mem(memBus), .memPsel(memPsel),
        .memPenable(memPenable), .memPwrite(memPwrite), .memPaddr(memPaddr),
        .memPwdata(memPwdata), .memPstrb(memPstrb), .memPrdata(memPrdata),
        .memPready(memPready)
    );

endmodule

/* hdl/lsuControl.sv */
// ########################################
// One access at a time, pready is a one-cycle pulse
// Misaligned accesses end in Lookup with pslverr
// ########################################
`timescale 1ns/1ps

module lsuControl import lsuPkg::*; (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input addrT paddr,
    input lsuCmdT cmd,
    input accessSizeT size,
    output logic pready,
    output logic pslverr,
    output wordT prdata,
    memReqIf.control mem,
    output indexT tagIndex,
    input logic readValid,
    input tagT readTag,
    input wordT loadWord,
    input lineT mergeLine,
    input byteMaskT mergeMask,
    output lineT storeLine,
    output byteMaskT storeMask,
    output logic dataWrite,
    output logic tagWrite,
    output logic writeValid,
    output tagT writeTag
);

    ctrlStateT state;
    tagT reqTag;
    indexT reqIndex;
    logic [1:0] wordSel;
    logic hit;
    logic misaligned;
    logic storeHit;
    wordT amoOld;

    always_comb begin
        reqTag = paddr[addrWidth-1 -: tagWidth];
        reqIndex = paddr[offsetWidth +: indexWidth];
        wordSel = paddr[offsetWidth-1:2];
        hit = readValid && (readTag == reqTag);
        case (size)
            SizeHalf: misaligned = paddr[0];
            SizeWord: misaligned = (paddr[1:0] != 2'b00);
            default:  misaligned = 1'b0;
        endcase
        storeHit = (state == Lookup) && hit && !misaligned &&
                   (cmd == CmdStore || cmd == CmdAmo);
    end

    // Engine owns the arrays while it refills or invalidates
    always_comb begin
        tagIndex = reqIndex;
        tagWrite = 1'b0;
        writeValid = 1'b0;
        writeTag = reqTag;
        dataWrite = storeHit;
        storeLine = mergeLine;
        storeMask = mergeMask;
        if (state == Refill || state == Invalidate) begin
            tagIndex = mem.arrayIndex;
            tagWrite = mem.arrayWrite;
            writeValid = (state == Refill);
            dataWrite = mem.arrayWrite && (state == Refill);
            storeLine = mem.fillLine;
            storeMask = '1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            pready <= 1'b0;
            pslverr <= 1'b0;
            mem.req <= 1'b0;
        end else begin
            pready <= 1'b0;
            case (state)
                Idle: begin
                    // Array read of reqIndex is issued in this cycle
                    if (psel && penable && !pready) begin
                        state <= Lookup;
                    end
                end
                Lookup: begin
                    if (cmd == CmdInvalidate) begin
                        mem.req <= 1'b1;
                        state <= Invalidate;
                    end else if (misaligned) begin
                        pready <= 1'b1;
                        pslverr <= 1'b1;
                        state <= Idle;
                    end else if (!hit) begin
                        mem.req <= 1'b1;
                        state <= Refill;
                    end else if (cmd == CmdLoad) begin
                        pready <= 1'b1;
                        pslverr <= 1'b0;
                        state <= Idle;
                    end else begin
                        mem.req <= 1'b1;
                        state <= WriteThrough;
                    end
                end
                Refill: begin
                    // Back to Idle to re-read the refilled line
                    if (mem.done) begin
                        mem.req <= 1'b0;
                        state <= Idle;
                    end
                end
                default: begin
                    if (mem.done) begin
                        mem.req <= 1'b0;
                        pready <= 1'b1;
                        pslverr <= 1'b0;
                        state <= Idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Lookup) begin
            mem.lineAddr <= {paddr[addrWidth-1:2], 2'b00};
            mem.wdata <= mergeLine.words[wordSel];
            mem.wstrb <= mergeMask[wordSel*wordBytes +: wordBytes];
            amoOld <= loadWord;
            if (cmd == CmdInvalidate) begin
                mem.cmd <= MemInvalidate;
            end else if (hit) begin
                mem.cmd <= MemWriteThrough;
            end else begin
                mem.cmd <= MemRefill;
            end
            prdata <= (cmd == CmdLoad && !misaligned) ? loadWord : '0;
        end else if (mem.done) begin
            prdata <= (cmd == CmdAmo) ? amoOld : '0;
        end
    end

endmodule

/* hdl/memEngine.sv */
// ########################################
// APB requester, word-aligned transfers only
// Refill reads offsets 0, 4, 8, 12 in order
// ########################################
`timescale 1ns/1ps

module memEngine import lsuPkg::*; (
    input logic clk,
    input logic rst,
    memReqIf.engine mem,
    output logic memPsel,
    output logic memPenable,
    output logic memPwrite,
    output addrT memPaddr,
    output wordT memPwdata,
    output logic [wordBytes-1:0] memPstrb,
    input wordT memPrdata,
    input logic memPready
);

    engStateT state;
    logic [1:0] beat;
    indexT walkIndex;
    indexT lineIndex;
    lineT fill;

    always_comb begin
        lineIndex = mem.lineAddr[offsetWidth +: indexWidth];
        memPsel = (state == EngSetup) || (state == EngAccess);
        memPenable = (state == EngAccess);
        memPwrite = (mem.cmd == MemWriteThrough);
        memPwdata = mem.wdata;
        memPstrb = memPwrite ? mem.wstrb : '0;
        if (memPwrite) begin
            memPaddr = {mem.lineAddr[addrWidth-1:2], 2'b00};
        end else begin
            memPaddr = {mem.lineAddr[addrWidth-1:offsetWidth], beat, 2'b00};
        end
        mem.fillLine = fill;
        mem.done = (state == EngDone);
        mem.arrayIndex = (state == EngInval) ? walkIndex : lineIndex;
        // Refilled line goes into the arrays together with done
        mem.arrayWrite = (state == EngInval) || (state == EngDone && mem.cmd == MemRefill);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EngIdle;
            beat <= '0;
            walkIndex <= '0;
        end else begin
            case (state)
                EngIdle: begin
                    if (mem.req) begin
                        beat <= '0;
                        walkIndex <= '0;
                        case (mem.cmd)
                            MemInvalidate: state <= EngInval;
                            MemNone:       state <= EngDone;
                            default:       state <= EngSetup;
                        endcase
                    end
                end
                EngSetup: state <= EngAccess;
                EngAccess: begin
                    if (memPready) begin
                        if (memPwrite || beat == 2'(lineWords - 1)) begin
                            state <= EngDone;
                        end else begin
                            beat <= beat + 1'b1;
                            state <= EngSetup;
                        end
                    end
                end
                EngInval: begin
                    walkIndex <= walkIndex + 1'b1;
                    if (walkIndex == '1) begin
                        state <= EngDone;
                    end
                end
                default: state <= EngIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EngAccess && memPready && !memPwrite) begin
            fill.words[beat] <= memPrdata;
        end
    end

endmodule

/* hdl/lineDatapath.sv */
// ########################################
// Offset assumed aligned to the access size
// ########################################
`timescale 1ns/1ps

module lineDatapath import lsuPkg::*; (
    input lineT line,
    input logic [offsetWidth-1:0] offset,
    input accessSizeT size,
    input logic isSigned,
    input logic isAmo,
    input amoFuncT amoFunc,
    input wordT storeData,
    output wordT loadWord,
    output lineT storeLine,
    output byteMaskT storeMask
);

    wordT rawWord;
    wordT shifted;
    wordT storeValue;
    logic [2:0] byteCount;
    logic [offsetWidth-1:0] pos;

    function automatic wordT amoAlu(amoFuncT func, wordT src, wordT old);
        case (func)
            AmoSwap: return src;
            AmoAdd:  return src + old;
            AmoXor:  return src ^ old;
            AmoAnd:  return src & old;
            AmoOr:   return src | old;
            AmoMin:  return ($signed(src) < $signed(old)) ? src : old;
            AmoMax:  return ($signed(src) > $signed(old)) ? src : old;
            AmoMinu: return (src < old) ? src : old;
            AmoMaxu: return (src > old) ? src : old;
            default: return old;
        endcase
    endfunction

    always_comb begin
        rawWord = line.words[offset[offsetWidth-1:2]];
        shifted = rawWord >> {offset[1:0], 3'b000};
        case (size)
            SizeByte: loadWord = {{24{isSigned & shifted[7]}}, shifted[7:0]};
            SizeHalf: loadWord = {{16{isSigned & shifted[15]}}, shifted[15:0]};
            default:  loadWord = rawWord;
        endcase
    end

    always_comb begin
        storeValue = isAmo ? amoAlu(amoFunc, storeData, rawWord) : storeData;
        case (size)
            SizeByte: byteCount = 3'd1;
            SizeHalf: byteCount = 3'd2;
            default:  byteCount = 3'd4;
        endcase
        storeLine = line;
        storeMask = '0;
        pos = offset;
        // Low bytes of the value land at the offset
        for (int i = 0; i < wordBytes; i++) begin
            pos = offset + offsetWidth'(i);
            if (i < byteCount) begin
                storeLine.bytes[pos] = storeValue[8*i +: 8];
                storeMask[pos] = 1'b1;
            end
        end
    end

endmodule

/* hdl/cacheArrays.sv */
// ########################################
// Registered reads, old data on a same-index write
// Only the valid bits are cleared by reset
// ########################################
`timescale 1ns/1ps

module cacheArrays import lsuPkg::*; (
    input logic clk,
    input logic rst,
    input indexT index,
    input logic tagWrite,
    input logic writeValid,
    input tagT writeTag,
    input logic dataWrite,
    input lineT writeLine,
    input byteMaskT writeMask,
    output logic readValid,
    output tagT readTag,
    output lineT readLine
);

    logic [lineCount-1:0] validBits;
    tagT tagMem [lineCount];
    lineT dataMem [lineCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            readValid <= 1'b0;
        end else begin
            if (tagWrite) begin
                validBits[index] <= writeValid;
            end
            readValid <= validBits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (tagWrite) begin
            tagMem[index] <= writeTag;
        end
        readTag <= tagMem[index];
    end

    // Byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < lineBytes; b++) begin
            if (dataWrite && writeMask[b]) begin
                dataMem[index].bytes[b] <= writeLine.bytes[b];
            end
        end
        readLine <= dataMem[index];
    end

endmodule

/* hdl/memReqIf.sv */
// ########################################
// Control holds req and fields until done
// ########################################
`timescale 1ns/1ps

interface memReqIf import lsuPkg::*; ();

    logic req;
    memCmdT cmd;
    addrT lineAddr;
    wordT wdata;
    logic [wordBytes-1:0] wstrb;
    lineT fillLine;
    indexT arrayIndex;
    logic arrayWrite;
    logic done;

    modport control (output req, cmd, lineAddr, wdata, wstrb,
                     input fillLine, arrayIndex, arrayWrite, done);
    modport engine (input req, cmd, lineAddr, wdata, wstrb,
                    output fillLine, arrayIndex, arrayWrite, done);

endinterface

/* hdl/lsuPkg.sv */
// ########################################
// Sizes are fixed here, 16-bit physical addresses
// Direct-mapped, 16 lines of 16 bytes
// ########################################
package lsuPkg;

    localparam int addrWidth = 16;
    localparam int wordWidth = 32;
    localparam int wordBytes = wordWidth / 8;
    localparam int lineBytes = 16;
    localparam int lineWords = 4;
    localparam int indexWidth = 4;
    localparam int offsetWidth = 4;
    localparam int tagWidth = addrWidth - indexWidth - offsetWidth;
    localparam int lineCount = 1 << indexWidth;

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [addrWidth-1:0] addrT;
    typedef logic [indexWidth-1:0] indexT;
    typedef logic [tagWidth-1:0] tagT;
    typedef logic [lineBytes-1:0] byteMaskT;

    // Byte view for load/store, word view for refill
    typedef union packed {
        logic [lineBytes-1:0][7:0] bytes;
        logic [lineWords-1:0][wordWidth-1:0] words;
    } lineT;

    typedef enum logic [1:0] {CmdLoad, CmdStore, CmdAmo, CmdInvalidate} lsuCmdT;
    typedef enum logic [1:0] {SizeByte, SizeHalf, SizeWord} accessSizeT;
    typedef enum logic [3:0] {
        AmoSwap, AmoAdd, AmoXor, AmoAnd, AmoOr, AmoMin, AmoMax, AmoMinu, AmoMaxu
    } amoFuncT;
    typedef enum logic [1:0] {MemNone, MemRefill, MemWriteThrough, MemInvalidate} memCmdT;

    typedef enum logic [2:0] {Idle, Lookup, Refill, WriteThrough, Invalidate} ctrlStateT;
    typedef enum logic [2:0] {EngIdle, EngSetup, EngAccess, EngInval, EngDone} engStateT;

endpackage
